// ==== hdl/mips_pkg.sv ====
package mips_pkg;

    // datapath widths
    parameter int XLEN   = 32;
    parameter int REG_AW = 5;

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [REG_AW-1:0] reg_addr_t;

    // register-register layout
    typedef struct packed {
        logic [5:0]  opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        logic [4:0]  shamt;
        logic [5:0]  funct;
    } inst_r_t;

    // immediate layout
    typedef struct packed {
        logic [5:0]  opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } inst_i_t;

    // one fetched word, seen through either layout
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } aluop_t;

    // major opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    // funct codes under OP_SPECIAL
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

endpackage

// ==== hdl/pipe_if.sv ====
`timescale 1ns/1ns

// decode/execute register contents
interface exe_bus_if;
    logic                           valid;
    mips_pkg::aluop_t               aluop;
    mips_pkg::word_t                src1;
    mips_pkg::word_t                src2;
    logic [mips_pkg::REG_AW-1:0]    shamt;
    logic                           wreg;
    mips_pkg::reg_addr_t            wa;
    mips_pkg::word_t                pc;

    modport src (output valid, aluop, src1, src2, shamt, wreg, wa, pc);
    modport dst (input  valid, aluop, src1, src2, shamt, wreg, wa, pc);
endinterface

// writeback register contents
interface wb_bus_if;
    logic                   wreg;
    mips_pkg::reg_addr_t    wa;
    mips_pkg::word_t        wd;
    mips_pkg::word_t        pc;

    modport src (output wreg, wa, wd, pc);
    // register file write port
    modport wr  (input wreg, wa, wd);
    // forwarding tap for decode
    modport fwd (input wreg, wa, wd);
endinterface

// ==== hdl/fetch_ctrl.sv ====
`timescale 1ns/1ns

module fetch_ctrl #(
    parameter mips_pkg::word_t RESET_PC = 32'hbfc0_0000
) (
    input  logic                cpu_clk_50m_i,
    input  logic                rst_i,
    input  logic                inst_ok_i,
    input  mips_pkg::word_t     inst_i,
    output logic                inst_req_o,
    output mips_pkg::word_t     iaddr_o,
    output logic                id_valid_o,
    output mips_pkg::inst_t     id_inst_o,
    output mips_pkg::word_t     id_pc_o
);

    typedef enum logic {
        IDLE,
        FETCH
    } state_t;

    state_t             state_q;
    mips_pkg::word_t    pc_q;
    logic               accept;
    logic               id_valid_q;
    mips_pkg::inst_t    id_inst_q;
    mips_pkg::word_t    id_pc_q;

    // request stays up in FETCH, address only moves on acceptance
    assign inst_req_o = (state_q == FETCH);
    assign iaddr_o    = pc_q;
    assign accept     = inst_req_o & inst_ok_i;

    // one idle cycle after reset, then fetch forever
    always_ff @(posedge cpu_clk_50m_i) begin
        if (rst_i) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE:    state_q <= FETCH;
                FETCH:   state_q <= FETCH;
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge cpu_clk_50m_i) begin
        if (rst_i) begin
            pc_q <= RESET_PC;
        end else if (accept) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    // valid bit of the fetch/decode register
    // a missed cycle becomes a bubble
    always_ff @(posedge cpu_clk_50m_i) begin
        if (rst_i) begin
            id_valid_q <= 1'b0;
        end else begin
            id_valid_q <= accept;
        end
    end

    // payload of the fetch/decode register
    always_ff @(posedge cpu_clk_50m_i) begin
        if (accept) begin
            id_inst_q <= inst_i;
            id_pc_q   <= pc_q;
        end
    end

    assign id_valid_o = id_valid_q;
    assign id_inst_o  = id_inst_q;
    assign id_pc_o    = id_pc_q;

endmodule

// ==== hdl/regfile.sv ====
`timescale 1ns/1ns

module regfile (
    input  logic                    cpu_clk_50m_i,
    input  logic                    rst_i,
    input  mips_pkg::reg_addr_t     ra1_i,
    input  mips_pkg::reg_addr_t     ra2_i,
    output mips_pkg::word_t         rd1_o,
    output mips_pkg::word_t         rd2_o,
    wb_bus_if.wr                    wb
);

    // r0 has no storage
    mips_pkg::word_t regs [1:31];

    // wb.wreg is never set for r0
    always_ff @(posedge cpu_clk_50m_i) begin
        if (rst_i) begin
            for (int n = 1; n < 32; n++) begin
                regs[n] <= '0;
            end
        end else if (wb.wreg) begin
            regs[wb.wa] <= wb.wd;
        end
    end

    // asynchronous reads
    always_comb begin
        if (ra1_i == '0) begin
            rd1_o = '0;
        end else begin
            rd1_o = regs[ra1_i];
        end
        if (ra2_i == '0) begin
            rd2_o = '0;
        end else begin
            rd2_o = regs[ra2_i];
        end
    end

endmodule

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage (
    input  logic                    cpu_clk_50m_i,
    input  logic                    rst_i,
    input  logic                    valid_i,
    input  mips_pkg::inst_t         inst_i,
    input  mips_pkg::word_t         pc_i,
    input  mips_pkg::word_t         rd1_i,
    input  mips_pkg::word_t         rd2_i,
    output mips_pkg::reg_addr_t     ra1_o,
    output mips_pkg::reg_addr_t     ra2_o,
    input  logic                    exe_fwd_wreg_i,
    input  mips_pkg::reg_addr_t     exe_fwd_wa_i,
    input  mips_pkg::word_t         exe_fwd_wd_i,
    wb_bus_if.fwd                   wb,
    exe_bus_if.src                  exe
);

    mips_pkg::aluop_t       aluop_d;
    logic                   known;
    logic                   use_imm;
    logic                   sign_ext;
    logic                   wreg_d;
    mips_pkg::reg_addr_t    wa_d;
    mips_pkg::word_t        imm_ext;
    mips_pkg::word_t        opnd1;
    mips_pkg::word_t        opnd2;

    // both source fields sit in the same place in either layout
    assign ra1_o = inst_i.r.rs;
    assign ra2_o = inst_i.r.rt;

    always_comb begin
        aluop_d  = mips_pkg::ALU_ADD;
        known    = 1'b1;
        use_imm  = 1'b1;
        sign_ext = 1'b0;
        wa_d     = inst_i.i.rt;
        case (inst_i.r.opcode)
            mips_pkg::OP_SPECIAL: begin
                use_imm = 1'b0;
                wa_d    = inst_i.r.rd;
                case (inst_i.r.funct)
                    mips_pkg::FN_ADDU: aluop_d = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: aluop_d = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:  aluop_d = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   aluop_d = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR:  aluop_d = mips_pkg::ALU_XOR;
                    mips_pkg::FN_SLT:  aluop_d = mips_pkg::ALU_SLT;
                    mips_pkg::FN_SLL:  aluop_d = mips_pkg::ALU_SLL;
                    mips_pkg::FN_SRL:  aluop_d = mips_pkg::ALU_SRL;
                    default:           known   = 1'b0;
                endcase
            end
            mips_pkg::OP_ADDIU: begin
                aluop_d  = mips_pkg::ALU_ADD;
                sign_ext = 1'b1;
            end
            mips_pkg::OP_ANDI: aluop_d = mips_pkg::ALU_AND;
            mips_pkg::OP_ORI:  aluop_d = mips_pkg::ALU_OR;
            mips_pkg::OP_LUI:  aluop_d = mips_pkg::ALU_LUI;
            default:           known   = 1'b0;
        endcase
    end

    // bubbles, unknown encodings and r0 never write
    assign wreg_d = valid_i & known & (wa_d != '0);

    assign imm_ext = sign_ext ?
        {{(mips_pkg::XLEN-16){inst_i.i.imm[15]}}, inst_i.i.imm} :
        {{(mips_pkg::XLEN-16){1'b0}}, inst_i.i.imm};

    // youngest result wins: execute, then writeback, then the file
    always_comb begin
        if (exe_fwd_wreg_i && exe_fwd_wa_i == ra1_o) begin
            opnd1 = exe_fwd_wd_i;
        end else if (wb.wreg && wb.wa == ra1_o) begin
            opnd1 = wb.wd;
        end else begin
            opnd1 = rd1_i;
        end
        if (exe_fwd_wreg_i && exe_fwd_wa_i == ra2_o) begin
            opnd2 = exe_fwd_wd_i;
        end else if (wb.wreg && wb.wa == ra2_o) begin
            opnd2 = wb.wd;
        end else begin
            opnd2 = rd2_i;
        end
    end

    // decode/execute register, control part
    always_ff @(posedge cpu_clk_50m_i) begin
        if (rst_i) begin
            exe.valid <= 1'b0;
            exe.wreg  <= 1'b0;
        end else begin
            exe.valid <= valid_i;
            exe.wreg  <= wreg_d;
        end
    end

    // payload
    always_ff @(posedge cpu_clk_50m_i) begin
        exe.aluop <= aluop_d;
        exe.src1  <= opnd1;
        exe.src2  <= use_imm ? imm_ext : opnd2;
        exe.shamt <= inst_i.r.shamt;
        exe.wa    <= wa_d;
        exe.pc    <= pc_i;
    end

endmodule

// ==== hdl/exe_stage.sv ====
`timescale 1ns/1ns

module exe_stage (
    input  logic                    cpu_clk_50m_i,
    input  logic                    rst_i,
    exe_bus_if.dst                  exe,
    output logic                    fwd_wreg_o,
    output mips_pkg::reg_addr_t     fwd_wa_o,
    output mips_pkg::word_t         fwd_wd_o,
    wb_bus_if.src                   wb
);

    mips_pkg::word_t    alu_res;
    logic               slt_bit;

    assign slt_bit = ($signed(exe.src1) < $signed(exe.src2));

    // shifts act on src2, as in MIPS sll/srl
    always_comb begin
        case (exe.aluop)
            mips_pkg::ALU_ADD: begin
                alu_res = exe.src1 + exe.src2;
            end
            mips_pkg::ALU_SUB: begin
                alu_res = exe.src1 - exe.src2;
            end
            mips_pkg::ALU_AND: begin
                alu_res = exe.src1 & exe.src2;
            end
            mips_pkg::ALU_OR: begin
                alu_res = exe.src1 | exe.src2;
            end
            mips_pkg::ALU_XOR: begin
                alu_res = exe.src1 ^ exe.src2;
            end
            mips_pkg::ALU_SLT: begin
                alu_res = {{(mips_pkg::XLEN-1){1'b0}}, slt_bit};
            end
            mips_pkg::ALU_SLL: begin
                alu_res = exe.src2 << exe.shamt;
            end
            mips_pkg::ALU_SRL: begin
                alu_res = exe.src2 >> exe.shamt;
            end
            mips_pkg::ALU_LUI: begin
                alu_res = {exe.src2[15:0], 16'h0000};
            end
            default: begin
                alu_res = '0;
            end
        endcase
    end

    // result goes back to decode in the same cycle
    assign fwd_wreg_o = exe.wreg;
    assign fwd_wa_o   = exe.wa;
    assign fwd_wd_o   = alu_res;

    // execute/writeback register
    always_ff @(posedge cpu_clk_50m_i) begin
        if (rst_i) begin
            wb.wreg <= 1'b0;
        end else begin
            wb.wreg <= exe.wreg;
        end
    end

    // payload only moves for real instructions
    // so the debug pc holds through bubbles
    always_ff @(posedge cpu_clk_50m_i) begin
        if (exe.valid) begin
            wb.wa <= exe.wa;
            wb.wd <= alu_res;
            wb.pc <= exe.pc;
        end
    end

endmodule

// ==== hdl/mini_mips32.sv ====
`timescale 1ns/1ns

module mini_mips32 #(
    parameter mips_pkg::word_t RESET_PC = 32'hbfc0_0000
) (
    input  logic                    cpu_clk_50m_i,
    input  logic                    rst_i,
    output logic                    inst_req_o,
    output mips_pkg::word_t         iaddr_o,
    input  logic                    inst_ok_i,
    input  mips_pkg::word_t         inst_i,
    output mips_pkg::word_t         debug_wb_pc_o,
    output logic [3:0]              debug_wb_rf_wen_o,
    output mips_pkg::reg_addr_t     debug_wb_rf_wnum_o,
    output mips_pkg::word_t         debug_wb_rf_wdata_o
);

    // fetch to decode
    logic                   id_valid;
    mips_pkg::inst_t        id_inst;
    mips_pkg::word_t        id_pc;

    // decode to register file
    mips_pkg::reg_addr_t    ra1;
    mips_pkg::reg_addr_t    ra2;
    mips_pkg::word_t        rd1;
    mips_pkg::word_t        rd2;

    // execute forward into decode
    logic                   exe_fwd_wreg;
    mips_pkg::reg_addr_t    exe_fwd_wa;
    mips_pkg::word_t        exe_fwd_wd;

    exe_bus_if exe_bus ();
    wb_bus_if  wb_bus ();

    fetch_ctrl #(
        .RESET_PC (RESET_PC)
    ) fetch_ctrl_i (
        .cpu_clk_50m_i (cpu_clk_50m_i),
        .rst_i         (rst_i),
        .inst_ok_i     (inst_ok_i),
        .inst_i        (inst_i),
        .inst_req_o    (inst_req_o),
        .iaddr_o       (iaddr_o),
        .id_valid_o    (id_valid),
        .id_inst_o     (id_inst),
        .id_pc_o       (id_pc)
    );

    regfile regfile_i (
        .cpu_clk_50m_i (cpu_clk_50m_i),
        .rst_i         (rst_i),
        .ra1_i         (ra1),
        .ra2_i         (ra2),
        .rd1_o         (rd1),
        .rd2_o         (rd2),
        .wb            (wb_bus.wr)
    );

    decode_stage decode_stage_i (
        .cpu_clk_50m_i  (cpu_clk_50m_i),
        .rst_i          (rst_i),
        .valid_i        (id_valid),
        .inst_i         (id_inst),
        .pc_i           (id_pc),
        .rd1_i          (rd1),
        .rd2_i          (rd2),
        .ra1_o          (ra1),
        .ra2_o          (ra2),
        .exe_fwd_wreg_i (exe_fwd_wreg),
        .exe_fwd_wa_i   (exe_fwd_wa),
        .exe_fwd_wd_i   (exe_fwd_wd),
        .wb             (wb_bus.fwd),
        .exe            (exe_bus.src)
    );

    exe_stage exe_stage_i (
        .cpu_clk_50m_i (cpu_clk_50m_i),
        .rst_i         (rst_i),
        .exe           (exe_bus.dst),
        .fwd_wreg_o    (exe_fwd_wreg),
        .fwd_wa_o      (exe_fwd_wa),
        .fwd_wd_o      (exe_fwd_wd),
        .wb            (wb_bus.src)
    );

    // debug view of the writeback register
    assign debug_wb_pc_o       = wb_bus.pc;
    assign debug_wb_rf_wen_o   = {4{wb_bus.wreg}};
    assign debug_wb_rf_wnum_o  = wb_bus.wa;
    assign debug_wb_rf_wdata_o = wb_bus.wd;

endmodule

// ==== bench/tb_mini_mips32.sv ====
`timescale 1ns/1ns

module tb_mini_mips32;

    localparam mips_pkg::word_t RESET_PC = 32'hbfc0_0000;
    localparam int TIMEOUT = 400;

    logic                   clk;
    logic                   rst;
    logic                   inst_req;
    mips_pkg::word_t        iaddr;
    logic                   inst_ok = 1'b0;
    mips_pkg::word_t        inst = '0;
    mips_pkg::word_t        wb_pc;
    logic [3:0]             wb_wen;
    mips_pkg::reg_addr_t    wb_wnum;
    mips_pkg::word_t        wb_wdata;

    // instruction memory, reference model and bookkeeping
    mips_pkg::word_t        prog [0:255];
    mips_pkg::word_t        mregs [0:31] = '{default: '0};
    logic [68:0]            exp_q [$];
    int                     prog_fill = 0;
    int                     n_loaded = 0;
    int                     acc_cnt = 0;
    int                     wb_seen = 0;
    int                     model_cnt = 0;
    int                     gap = 0;
    int                     errors = 0;
    int                     tests_run = 0;
    int                     tests_failed = 0;
    logic                   fast = 1'b0;
    logic [31:0]            seed = 32'hb5d1_3cc3;
    string                  cur_test = "none";
    mips_pkg::word_t        last_acc;
    mips_pkg::word_t        prev_addr;
    logic                   prev_req;
    logic                   prev_acc;

    mini_mips32 dut_i (
        .cpu_clk_50m_i       (clk),
        .rst_i               (rst),
        .inst_req_o          (inst_req),
        .iaddr_o             (iaddr),
        .inst_ok_i           (inst_ok),
        .inst_i              (inst),
        .debug_wb_pc_o       (wb_pc),
        .debug_wb_rf_wen_o   (wb_wen),
        .debug_wb_rf_wnum_o  (wb_wnum),
        .debug_wb_rf_wdata_o (wb_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic mips_pkg::word_t asm_r(input logic [5:0] fn, input logic [4:0] rd,
                                              input logic [4:0] rs, input logic [4:0] rt,
                                              input logic [4:0] sh);
        return {mips_pkg::OP_SPECIAL, rs, rt, rd, sh, fn};
    endfunction

    function automatic mips_pkg::word_t asm_i(input logic [5:0] op, input logic [4:0] rt,
                                              input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic mismatch(input string what, input mips_pkg::word_t exp,
                            input mips_pkg::word_t act);
        $display("FAILED %s: %s expected %h actual %h", cur_test, what, exp, act);
        errors++;
    endtask

    task automatic flag_error(input string msg);
        $display("ERROR %s: %s", cur_test, msg);
        errors++;
    endtask

    task automatic emit(input mips_pkg::word_t w);
        prog[prog_fill] = w;
        prog_fill++;
    endtask

    // MIPS semantics of the kept subset, queue what should retire
    task automatic model_exec(input mips_pkg::word_t pc, input mips_pkg::word_t w);
        mips_pkg::word_t a;
        mips_pkg::word_t b;
        mips_pkg::word_t res;
        logic [4:0]      dst;
        logic            wr;
        a   = mregs[w[25:21]];
        b   = mregs[w[20:16]];
        dst = w[20:16];
        res = '0;
        wr  = 1'b1;
        if (w[31:26] == mips_pkg::OP_SPECIAL) begin
            dst = w[15:11];
            case (w[5:0])
                mips_pkg::FN_ADDU: res = a + b;
                mips_pkg::FN_SUBU: res = a - b;
                mips_pkg::FN_AND:  res = a & b;
                mips_pkg::FN_OR:   res = a | b;
                mips_pkg::FN_XOR:  res = a ^ b;
                mips_pkg::FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                mips_pkg::FN_SLL:  res = b << w[10:6];
                mips_pkg::FN_SRL:  res = b >> w[10:6];
                default:           wr = 1'b0;
            endcase
        end else begin
            case (w[31:26])
                mips_pkg::OP_ADDIU: res = a + {{16{w[15]}}, w[15:0]};
                mips_pkg::OP_ANDI:  res = a & {16'h0000, w[15:0]};
                mips_pkg::OP_ORI:   res = a | {16'h0000, w[15:0]};
                mips_pkg::OP_LUI:   res = {w[15:0], 16'h0000};
                default:            wr = 1'b0;
            endcase
        end
        if (wr && dst != 5'd0) begin
            mregs[dst] = res;
            exp_q.push_back({pc, dst, res});
            model_cnt++;
        end
    endtask

    // instruction memory: random gap after each accept, nothing beyond the loaded program
    always @(posedge clk) begin : imem
        mips_pkg::word_t nxt;
        int              idx;
        if (rst) begin
            inst_ok <= 1'b0;
            gap = 0;
        end else begin
            nxt = iaddr;
            if (inst_req && inst_ok) begin
                nxt = iaddr + 32'd4;
                gap = fast ? 0 : int'(next_rand() >> 30);
            end
            idx = int'((nxt - RESET_PC) >> 2);
            if (gap > 0) begin
                gap--;
                inst_ok <= 1'b0;
            end else if (inst_req && idx < n_loaded) begin
                inst_ok <= 1'b1;
                inst    <= prog[idx];
            end else begin
                inst_ok <= 1'b0;
            end
        end
    end

    // writeback compare, fetch order checks and model stepping
    always @(posedge clk) begin : observe
        logic [68:0] e;
        if (rst) begin
            last_acc = RESET_PC - 32'd4;
            prev_req = 1'b0;
            prev_acc = 1'b0;
        end else begin
            if (wb_wen != 4'h0) begin
                wb_seen++;
                if (wb_wen != 4'hf) begin
                    flag_error("write enable bits disagree");
                end
                if (exp_q.size() == 0) begin
                    flag_error("writeback seen with nothing expected");
                end else begin
                    e = exp_q.pop_front();
                    if (wb_pc !== e[68:37]) begin
                        mismatch("wb pc", e[68:37], wb_pc);
                    end
                    if (wb_wnum !== e[36:32]) begin
                        mismatch("wb wnum", {27'd0, e[36:32]}, {27'd0, wb_wnum});
                    end
                    if (wb_wdata !== e[31:0]) begin
                        mismatch("wb wdata", e[31:0], wb_wdata);
                    end
                end
            end
            if (prev_req && !prev_acc && iaddr !== prev_addr) begin
                flag_error("iaddr_o moved while the request was waiting");
            end
            if (inst_req && inst_ok) begin
                if (iaddr !== last_acc + 32'd4) begin
                    mismatch("accepted address", last_acc + 32'd4, iaddr);
                end
                last_acc = last_acc + 32'd4;
                acc_cnt++;
                model_exec(last_acc, inst);
            end
            prev_req  = inst_req;
            prev_acc  = inst_req && inst_ok;
            prev_addr = iaddr;
        end
    end

    task automatic begin_test(input string name);
        cur_test = name;
        errors   = 0;
    endtask

    // hand the new words to the memory and wait until all of it has retired
    task automatic run_program();
        int t;
        n_loaded <= prog_fill;
        t = 0;
        while ((acc_cnt < prog_fill || exp_q.size() != 0) && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (t >= TIMEOUT) begin
            flag_error("timed out waiting for the program to retire");
        end
        repeat (4) @(negedge clk);
        if (wb_seen != model_cnt) begin
            mismatch("writeback count", model_cnt, wb_seen);
        end
        tests_run++;
        if (errors != 0) begin
            tests_failed++;
        end
        $display("test %s: %0d errors", cur_test, errors);
    endtask

    task automatic test_reset();
        int t;
        begin_test("reset");
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            if (inst_req === 1'b1 || (|wb_wen) === 1'b1) begin
                flag_error("request or write enable high during reset");
            end
        end
        rst <= 1'b0;
        @(posedge clk);
        if (inst_req === 1'b1 || (|wb_wen) === 1'b1) begin
            flag_error("request or write enable high in the first cycle after reset");
        end
        t = 0;
        while (inst_req !== 1'b1 && t < 10) begin
            @(posedge clk);
            t++;
        end
        if (t >= 10) begin
            flag_error("no instruction request after reset");
        end else if (iaddr !== RESET_PC) begin
            mismatch("first iaddr_o", RESET_PC, iaddr);
        end
        run_program();
    endtask

    task automatic test_fetch_order();
        begin_test("fetch order");
        fast = 1'b0;
        for (int n = 0; n < 16; n++) begin
            emit(asm_i(mips_pkg::OP_ADDIU, 5'd1, 5'd1, 16'd3));
        end
        run_program();
    endtask

    task automatic test_immediates();
        begin_test("immediates");
        fast = 1'b0;
        emit(asm_i(mips_pkg::OP_ORI, 5'd1, 5'd0, 16'h8001));
        emit(asm_i(mips_pkg::OP_ADDIU, 5'd2, 5'd0, 16'h8000));
        emit(asm_i(mips_pkg::OP_ANDI, 5'd3, 5'd2, 16'hf0f0));
        emit(asm_i(mips_pkg::OP_LUI, 5'd4, 5'd0, 16'h1234));
        emit(asm_i(mips_pkg::OP_ADDIU, 5'd5, 5'd4, 16'hffff));
        emit(asm_i(mips_pkg::OP_ORI, 5'd6, 5'd4, 16'habcd));
        run_program();
    endtask

    // each step reads the previous result and the one two back
    task automatic test_forwarding();
        begin_test("forwarding");
        for (int p = 0; p < 2; p++) begin
            fast = (p == 0);
            // new base each pass, so stale registers hold other values
            emit(asm_i(mips_pkg::OP_ADDIU, 5'd4, 5'd4, 16'h0f0f));
            emit(asm_r(mips_pkg::FN_ADDU, 5'd7, 5'd1, 5'd4, 5'd0));
            emit(asm_r(mips_pkg::FN_SUBU, 5'd8, 5'd7, 5'd1, 5'd0));
            emit(asm_r(mips_pkg::FN_XOR, 5'd9, 5'd8, 5'd7, 5'd0));
            emit(asm_r(mips_pkg::FN_OR, 5'd10, 5'd9, 5'd8, 5'd0));
            emit(asm_r(mips_pkg::FN_SLT, 5'd11, 5'd9, 5'd10, 5'd0));
            emit(asm_r(mips_pkg::FN_ADDU, 5'd12, 5'd11, 5'd10, 5'd0));
            emit(asm_r(mips_pkg::FN_SLL, 5'd13, 5'd0, 5'd12, 5'd4));
            emit(asm_r(mips_pkg::FN_SRL, 5'd14, 5'd0, 5'd13, 5'd3));
            run_program();
        end
    endtask

    task automatic test_zero_and_unknown();
        begin_test("zero and unknown");
        fast = 1'b0;
        emit(asm_i(mips_pkg::OP_ORI, 5'd15, 5'd0, 16'h0077));
        emit(asm_i(mips_pkg::OP_ORI, 5'd0, 5'd15, 16'h0055));
        emit(asm_r(mips_pkg::FN_ADDU, 5'd0, 5'd15, 5'd15, 5'd0));
        // lw and mult are outside the subset
        emit({6'h23, 5'd1, 5'd15, 16'h0000});
        emit(asm_r(6'h18, 5'd15, 5'd1, 5'd2, 5'd0));
        emit(asm_r(mips_pkg::FN_ADDU, 5'd16, 5'd0, 5'd15, 5'd0));
        emit(asm_r(mips_pkg::FN_OR, 5'd17, 5'd0, 5'd0, 5'd0));
        run_program();
    endtask

    task automatic test_random_program();
        logic [31:0] r;
        logic [31:0] s;
        int          k;
        logic [5:0]  fns [8];
        logic [5:0]  ops [4];
        fns = '{mips_pkg::FN_ADDU, mips_pkg::FN_SUBU, mips_pkg::FN_AND, mips_pkg::FN_OR,
                mips_pkg::FN_XOR, mips_pkg::FN_SLT, mips_pkg::FN_SLL, mips_pkg::FN_SRL};
        ops = '{mips_pkg::OP_ADDIU, mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_LUI};
        begin_test("random program");
        fast = 1'b0;
        // small register range keeps dependencies close together
        for (int n = 0; n < 40; n++) begin
            r = next_rand();
            s = next_rand();
            k = int'((r >> 16) % 32'd12);
            if (k < 8) begin
                emit(asm_r(fns[k], {2'b00, r[2:0]}, {2'b00, r[5:3]}, {2'b00, r[8:6]}, r[13:9]));
            end else begin
                emit(asm_i(ops[k-8], {2'b00, r[2:0]}, {2'b00, r[5:3]}, s[31:16]));
            end
        end
        run_program();
    endtask

    initial begin
        rst = 1'b1;
        test_reset();
        test_fetch_order();
        test_immediates();
        test_forwarding();
        test_zero_and_unknown();
        test_random_program();
        $display("tests run %0d, failed %0d, writebacks %0d", tests_run, tests_failed, wb_seen);
        if (tests_failed == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== mini_mips32.f ====
hdl/mips_pkg.sv
hdl/pipe_if.sv
hdl/fetch_ctrl.sv
hdl/regfile.sv
hdl/decode_stage.sv
hdl/exe_stage.sv
hdl/mini_mips32.sv
bench/tb_mini_mips32.sv

// ==== run.sh ====
#!/bin/sh
# compile with Verilator, run, then look for the fail message in the log
rm -rf obj_dir sim.log
verilator --binary --timing -f mini_mips32.f --top-module tb_mini_mips32 -o sim_mini_mips32 \
    && ./obj_dir/sim_mini_mips32 > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1 || exit 0
